// File: verilog/mmio_consts.svh
// Byte addresses are {addr[14:0], byte_select}; UART bit time 2 or more, prescales 1 or more
`ifndef MMIO_CONSTS_SVH
`define MMIO_CONSTS_SVH

// Register map
`define LED_ADDR          16'hFF00
`define SWITCH_ADDR       16'hFF01
`define UART_DATA_ADDR    16'hFF02
`define UART_STATUS_ADDR  16'hFF03
`define TIMER_DATA_ADDR   16'hFF04
`define SOUND_DATA_ADDR   16'hFF06

// Reads at or above this count as serviced
`define IO_BASE           16'hFF00

// Clocks per UART bit
`define UART_CLKS_PER_BIT 8

// Clocks per timer tick
`define TIMER_PRESCALE    4

// Clocks per half-period unit of the tone
`define SOUND_PRESCALE    2

`endif

// File: verilog/mmio_pkg.sv
// Shared data and state types of the I/O block; the two UART FSMs use prefixed literals in one scope
package mmio_pkg;

    typedef logic [15:0] word_t;
    typedef logic [7:0]  byte_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } uart_tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } uart_rx_state_t;

    // Register picked by a decoded byte address
    typedef enum logic [2:0] {
        LEDS,
        SWITCHES,
        UART_DATA,
        UART_STATUS,
        TIMER,
        NONE
    } reg_sel_t;

endpackage

// File: verilog/uart_controller.sv
// 8N1 UART at a fixed bit time; one receive byte, no framing check, unread bytes get overwritten
`timescale 1ns/1ps
`include "mmio_consts.svh"

module uart_controller (
    input  logic            clk,
    input  logic            rst,
    input  logic            wr_en,
    input  logic            rd_en,
    input  mmio_pkg::word_t data_in,
    input  logic            rx,
    output mmio_pkg::byte_t data_out,
    output mmio_pkg::byte_t status_out,
    output logic            tx,
    output logic            uart_wait
);

    localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT) + 1;
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(`UART_CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] BIT_HALF = CNT_W'(`UART_CLKS_PER_BIT / 2 - 1);

    mmio_pkg::uart_tx_state_t tx_state;
    logic [CNT_W-1:0]         tx_clk;
    logic [2:0]               tx_idx;
    mmio_pkg::byte_t          tx_shift;
    logic                     tx_load;
    logic                     tx_bit_end;

    mmio_pkg::uart_rx_state_t rx_state;
    logic [CNT_W-1:0]         rx_clk;
    logic [2:0]               rx_idx;
    mmio_pkg::byte_t          rx_shift;
    mmio_pkg::byte_t          rx_data;
    logic                     rx_meta;
    logic                     rx_s;
    logic                     rx_ready;
    logic                     rx_sample;
    logic                     rx_done;

    assign tx_load    = wr_en & (tx_state == mmio_pkg::TX_IDLE);
    assign tx_bit_end = (tx_clk == BIT_LAST);
    assign uart_wait  = wr_en & (tx_state != mmio_pkg::TX_IDLE);

    assign data_out   = rx_data;
    assign status_out = {6'b0, rx_ready, tx_state != mmio_pkg::TX_IDLE};

    // Transmit FSM, tx registered so the line never glitches
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_state <= mmio_pkg::TX_IDLE;
            tx       <= 1'b1;
            tx_clk   <= '0;
            tx_idx   <= '0;
        end else begin
            case (tx_state)
                mmio_pkg::TX_IDLE: begin
                    if (tx_load) begin
                        tx       <= 1'b0;
                        tx_clk   <= '0;
                        tx_state <= mmio_pkg::TX_START;
                    end
                end
                mmio_pkg::TX_START: begin
                    if (tx_bit_end) begin
                        tx_clk   <= '0;
                        tx_idx   <= '0;
                        tx       <= tx_shift[0];
                        tx_state <= mmio_pkg::TX_DATA;
                    end else begin
                        tx_clk <= tx_clk + 1'b1;
                    end
                end
                mmio_pkg::TX_DATA: begin
                    if (tx_bit_end) begin
                        tx_clk <= '0;
                        tx_idx <= tx_idx + 1'b1;
                        if (tx_idx == 3'd7) begin
                            tx       <= 1'b1;
                            tx_state <= mmio_pkg::TX_STOP;
                        end else begin
                            tx <= tx_shift[1];
                        end
                    end else begin
                        tx_clk <= tx_clk + 1'b1;
                    end
                end
                default: begin
                    if (tx_bit_end) begin
                        tx_clk   <= '0;
                        tx_state <= mmio_pkg::TX_IDLE;
                    end else begin
                        tx_clk <= tx_clk + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (tx_load) begin
            tx_shift <= data_in[7:0];
        end else if (tx_state == mmio_pkg::TX_DATA && tx_bit_end) begin
            tx_shift <= {1'b0, tx_shift[7:1]};
        end
    end

    // Line idles high
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_s    <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_s    <= rx_meta;
        end
    end

    assign rx_sample = (rx_state == mmio_pkg::RX_DATA) && (rx_clk == BIT_LAST);
    assign rx_done   = (rx_state == mmio_pkg::RX_STOP) && (rx_clk == BIT_LAST);

    // Receive FSM, samples at mid-bit after a half-bit start check
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_state <= mmio_pkg::RX_IDLE;
            rx_clk   <= '0;
            rx_idx   <= '0;
        end else begin
            case (rx_state)
                mmio_pkg::RX_IDLE: begin
                    rx_clk <= '0;
                    if (!rx_s) begin
                        rx_state <= mmio_pkg::RX_START;
                    end
                end
                mmio_pkg::RX_START: begin
                    if (rx_clk == BIT_HALF) begin
                        rx_clk   <= '0;
                        rx_idx   <= '0;
                        rx_state <= rx_s ? mmio_pkg::RX_IDLE : mmio_pkg::RX_DATA;
                    end else begin
                        rx_clk <= rx_clk + 1'b1;
                    end
                end
                mmio_pkg::RX_DATA: begin
                    if (rx_sample) begin
                        rx_clk <= '0;
                        rx_idx <= rx_idx + 1'b1;
                        if (rx_idx == 3'd7) begin
                            rx_state <= mmio_pkg::RX_STOP;
                        end
                    end else begin
                        rx_clk <= rx_clk + 1'b1;
                    end
                end
                default: begin
                    if (rx_done) begin
                        rx_clk   <= '0;
                        rx_state <= mmio_pkg::RX_IDLE;
                    end else begin
                        rx_clk <= rx_clk + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rx_sample) begin
            rx_shift <= {rx_s, rx_shift[7:1]};
        end
    end

    // A finished byte wins over a read on the same edge
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_ready <= 1'b0;
            rx_data  <= '0;
        end else if (rx_done) begin
            rx_ready <= 1'b1;
            rx_data  <= rx_shift;
        end else if (rd_en) begin
            rx_ready <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (tx_state == mmio_pkg::TX_IDLE) |-> tx)
    else $error("tx low while the transmitter is idle");

endmodule

// File: verilog/timer.sv
// 16-bit count, no compare or overflow event; a write reloads it and restarts the prescaler
`timescale 1ns/1ps
`include "mmio_consts.svh"

module timer (
    input  logic            clk,
    input  logic            rst,
    input  logic            wr_en,
    input  mmio_pkg::word_t data_in,
    output mmio_pkg::word_t data_out
);

    localparam int PRE_W = $clog2(`TIMER_PRESCALE) + 1;
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(`TIMER_PRESCALE - 1);

    logic [PRE_W-1:0] pre_cnt;
    mmio_pkg::word_t  count;

    assign data_out = count;

    always_ff @(posedge clk) begin
        if (rst) begin
            pre_cnt <= '0;
            count   <= '0;
        end else if (wr_en) begin
            pre_cnt <= '0;
            count   <= data_in;
        end else if (pre_cnt == PRE_LAST) begin
            pre_cnt <= '0;
            // Wraps at 16 bits
            count   <= count + 1'b1;
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

endmodule

// File: verilog/sound.sv
// Square wave only with no envelope or mixing; bits 11:0 set the half period and bits 15:12 the level
`timescale 1ns/1ps
`include "mmio_consts.svh"

module sound (
    input  logic            clk,
    input  logic            rst,
    input  logic            wr_en,
    input  mmio_pkg::word_t data_in,
    output logic            snd_out,
    output logic [3:0]      snd_signals
);

    localparam int PRE_W = $clog2(`SOUND_PRESCALE) + 1;
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(`SOUND_PRESCALE - 1);

    logic [11:0]      period;
    logic [11:0]      half_cnt;
    logic [PRE_W-1:0] pre_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            period      <= '0;
            snd_signals <= '0;
            snd_out     <= 1'b0;
            pre_cnt     <= '0;
            half_cnt    <= '0;
        end else if (wr_en) begin
            period      <= data_in[11:0];
            snd_signals <= data_in[15:12];
            // New tone restarts from low
            snd_out     <= 1'b0;
            pre_cnt     <= '0;
            half_cnt    <= '0;
        end else if (period == 12'd0) begin
            snd_out  <= 1'b0;
            pre_cnt  <= '0;
            half_cnt <= '0;
        end else if (pre_cnt == PRE_LAST) begin
            pre_cnt <= '0;
            if (half_cnt == period - 12'd1) begin
                half_cnt <= '0;
                snd_out  <= ~snd_out;
            end else begin
                half_cnt <= half_cnt + 12'd1;
            end
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (period == 12'd0) |-> !snd_out)
    else $error("snd_out high with a zero period");

endmodule

// File: verilog/mmio.sv
// Reads return one cycle later and the CPU must hold a UART data write until mem_wait falls
`timescale 1ns/1ps
`include "mmio_consts.svh"

module mmio (
    input  logic            clk,
    input  logic            rst,
    input  logic            en,
    input  logic            write_enable,
    input  logic            byte_select,
    input  mmio_pkg::word_t addr,
    input  mmio_pkg::word_t data_in,
    input  logic [3:0]      switches,
    input  logic            rx,
    output mmio_pkg::word_t data_out,
    output logic [7:0]      led_out,
    output logic            serviced_read,
    output logic            tx,
    output logic            snd_out,
    output logic [3:0]      snd_signals,
    output logic            mem_wait
);

    mmio_pkg::word_t    real_addr;
    mmio_pkg::reg_sel_t sel;
    logic               rd_req;
    logic               wr_req;
    logic               wr_go;
    logic               led_wr_en;
    logic               uart_wr_en;
    logic               uart_rd_en;
    logic               timer_wr_en;
    logic               sound_wr_en;
    logic               uart_wait;
    mmio_pkg::byte_t    uart_data;
    mmio_pkg::byte_t    uart_status;
    mmio_pkg::word_t    timer_data;
    logic [3:0]         switch_meta;
    logic [3:0]         switch_sync;

    assign real_addr = {addr[14:0], byte_select};

    always_comb begin
        case (real_addr)
            `LED_ADDR:         sel = mmio_pkg::LEDS;
            `SWITCH_ADDR:      sel = mmio_pkg::SWITCHES;
            `UART_DATA_ADDR:   sel = mmio_pkg::UART_DATA;
            `UART_STATUS_ADDR: sel = mmio_pkg::UART_STATUS;
            `TIMER_DATA_ADDR:  sel = mmio_pkg::TIMER;
            default:           sel = mmio_pkg::NONE;
        endcase
    end

    assign rd_req = en & ~write_enable;
    assign wr_req = en & write_enable;
    // Writes held off while the CPU is stalled
    assign wr_go  = wr_req & ~mem_wait;

    assign led_wr_en   = wr_go & (sel == mmio_pkg::LEDS);
    // UART takes the raw request and accepts it only once idle
    assign uart_wr_en  = wr_req & (sel == mmio_pkg::UART_DATA);
    assign uart_rd_en  = rd_req & (sel == mmio_pkg::UART_DATA);
    assign timer_wr_en = wr_go & (sel == mmio_pkg::TIMER);
    assign sound_wr_en = wr_go & (real_addr == `SOUND_DATA_ADDR);

    assign mem_wait = uart_wait;

    always_ff @(posedge clk) begin
        if (rst) begin
            led_out <= '0;
        end else if (led_wr_en) begin
            led_out <= data_in[7:0];
        end
    end

    // Two-stage switch synchroniser
    always_ff @(posedge clk) begin
        switch_meta <= switches;
        switch_sync <= switch_meta;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            data_out      <= '0;
            serviced_read <= 1'b0;
        end else begin
            serviced_read <= rd_req & (real_addr >= `IO_BASE);
            if (rd_req) begin
                case (sel)
                    mmio_pkg::LEDS:        data_out <= {8'h00, led_out};
                    mmio_pkg::SWITCHES:    data_out <= {12'h000, switch_sync};
                    mmio_pkg::UART_DATA:   data_out <= {8'h00, uart_data};
                    mmio_pkg::UART_STATUS: data_out <= {8'h00, uart_status};
                    mmio_pkg::TIMER:       data_out <= timer_data;
                    default:               data_out <= '0;
                endcase
            end
        end
    end

    uart_controller uart (
        .clk        (clk),
        .rst        (rst),
        .wr_en      (uart_wr_en),
        .rd_en      (uart_rd_en),
        .data_in    (data_in),
        .rx         (rx),
        .data_out   (uart_data),
        .status_out (uart_status),
        .tx         (tx),
        .uart_wait  (uart_wait)
    );

    timer timer (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (timer_wr_en),
        .data_in  (data_in),
        .data_out (timer_data)
    );

    sound sound (
        .clk         (clk),
        .rst         (rst),
        .wr_en       (sound_wr_en),
        .data_in     (data_in),
        .snd_out     (snd_out),
        .snd_signals (snd_signals)
    );

    assert property (@(posedge clk) disable iff (rst)
        serviced_read |-> $past(rd_req && (real_addr >= `IO_BASE)))
    else $error("serviced_read without an I/O read on the previous cycle");

    // A stall only comes from a UART data write to a busy transmitter
    assert property (@(posedge clk) disable iff (rst)
        mem_wait |-> (uart_wr_en && uart_status[0]))
    else $error("mem_wait without a UART data write to a busy transmitter");

    // Bus-written registers hold while the CPU is stalled
    assert property (@(posedge clk) disable iff (rst)
        mem_wait |=> ($stable(led_out) && $stable(snd_signals)))
    else $error("write taken while mem_wait is high");

endmodule

// File: sim/tb_mmio.sv
// Run from the project root; reads sim/mmio_golden.txt and ties tx back to rx
`timescale 1ns/1ps
`include "mmio_consts.svh"

module tb_mmio;

    localparam int WAIT_LIMIT = 400;
    localparam int POLL_LIMIT = 200;

    logic        clk;
    logic        rst;
    logic        en;
    logic        write_enable;
    logic        byte_select;
    logic [15:0] addr;
    logic [15:0] data_in;
    logic [3:0]  switches;
    logic [15:0] data_out;
    logic [7:0]  led_out;
    logic        serviced_read;
    logic        serial;
    logic        snd_out;
    logic [3:0]  snd_signals;
    logic        mem_wait;

    // Serial loopback through one net
    mmio UUT (
        .clk           (clk),
        .rst           (rst),
        .en            (en),
        .write_enable  (write_enable),
        .byte_select   (byte_select),
        .addr          (addr),
        .data_in       (data_in),
        .switches      (switches),
        .rx            (serial),
        .data_out      (data_out),
        .led_out       (led_out),
        .serviced_read (serviced_read),
        .tx            (serial),
        .snd_out       (snd_out),
        .snd_signals   (snd_signals),
        .mem_wait      (mem_wait)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("Fail %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // True when v lies in [lo, hi], counting across the 16-bit wrap
    function automatic logic in_window(input logic [15:0] v, input logic [15:0] lo,
                                       input logic [15:0] hi);
        logic [15:0] off;
        logic [15:0] span;
        off  = v - lo;
        span = hi - lo;
        return off <= span;
    endfunction

    // Byte address split into word address and byte_select
    task automatic bus_write(input logic [15:0] a, input logic [15:0] d, output int stalls);
        int n;
        n = 0;
        @(posedge clk);
        en           <= 1'b1;
        write_enable <= 1'b1;
        addr         <= {1'b0, a[15:1]};
        byte_select  <= a[0];
        data_in      <= d;
        @(negedge clk);
        while (mem_wait) begin
            n++;
            if (n > WAIT_LIMIT) begin
                stop_run("Timed out waiting for mem_wait to fall");
            end
            @(negedge clk);
        end
        // Write taken on this edge
        @(posedge clk);
        en           <= 1'b0;
        write_enable <= 1'b0;
        stalls = n;
    endtask

    task automatic bus_read(input logic [15:0] a, output logic [15:0] d);
        @(posedge clk);
        en           <= 1'b1;
        write_enable <= 1'b0;
        addr         <= {1'b0, a[15:1]};
        byte_select  <= a[0];
        @(posedge clk);
        en <= 1'b0;
        @(negedge clk);
        d = data_out;
        check("serviced_read", 32'(serviced_read), 32'(a >= `IO_BASE));
        @(negedge clk);
        check("serviced_read", 32'(serviced_read), 32'd0);
    endtask

    task automatic wait_ready();
        logic [15:0] st;
        int polls;
        polls = 0;
        bus_read(`UART_STATUS_ADDR, st);
        while (!st[1]) begin
            polls++;
            if (polls > POLL_LIMIT) begin
                stop_run("Timed out waiting for a received UART byte");
            end
            bus_read(`UART_STATUS_ADDR, st);
        end
    endtask

    // Second write must stall behind the first frame
    task automatic run_uart(input logic [7:0] b1, input logic [7:0] b2);
        int stalls;
        logic [15:0] d;
        bus_write(`UART_DATA_ADDR, {8'h00, b1}, stalls);
        check("mem_wait", 32'(stalls), 32'd0);
        bus_write(`UART_DATA_ADDR, {8'h00, b2}, stalls);
        check("mem_wait", 32'(stalls != 0), 32'd1);
        wait_ready();
        bus_read(`UART_DATA_ADDR, d);
        check("data_out", 32'(d), 32'(b1));
        bus_read(`UART_STATUS_ADDR, d);
        check("data_out[1]", 32'(d[1]), 32'd0);
        wait_ready();
        bus_read(`UART_DATA_ADDR, d);
        check("data_out", 32'(d), 32'(b2));
        bus_read(`UART_STATUS_ADDR, d);
        check("data_out[1]", 32'(d[1]), 32'd0);
    endtask

    task automatic run_timer(input logic [15:0] load, input logic [31:0] cycles,
                             input logic [15:0] lo, input logic [15:0] hi);
        int stalls;
        logic [15:0] d;
        bus_write(`TIMER_DATA_ADDR, load, stalls);
        check("mem_wait", 32'(stalls), 32'd0);
        repeat (cycles) @(posedge clk);
        bus_read(`TIMER_DATA_ADDR, d);
        check($sformatf("data_out 0x%h in 0x%h to 0x%h", d, lo, hi),
              32'(in_window(d, lo, hi)), 32'd1);
    endtask

    task automatic run_sound(input logic [15:0] w, input logic [31:0] window,
                             input logic [15:0] exp);
        int stalls;
        int toggles;
        logic prev;
        bus_write(`SOUND_DATA_ADDR, w, stalls);
        check("mem_wait", 32'(stalls), 32'd0);
        @(negedge clk);
        check("snd_signals", 32'(snd_signals), 32'(w[15:12]));
        prev = snd_out;
        toggles = 0;
        repeat (window) begin
            @(negedge clk);
            if (snd_out !== prev) begin
                toggles++;
            end
            prev = snd_out;
        end
        if (w[11:0] == 12'd0) begin
            check("snd_out toggles", 32'(toggles), 32'd0);
            check("snd_out", 32'(snd_out), 32'd0);
        end else begin
            check($sformatf("snd_out toggles 0x%h within 1 of 0x%h", 16'(toggles), exp),
                  32'(in_window(16'(toggles), exp - 16'd1, exp + 16'd1)), 32'd1);
        end
    endtask

    task automatic idle_gap();
        repeat ($urandom % 4) @(posedge clk);
    endtask

    initial begin
        int fd;
        int n;
        int cmds;
        int stalls;
        string line;
        logic [7:0] op;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        logic [15:0] d;
        void'($urandom(30));
        rst          = 1'b1;
        en           = 1'b0;
        write_enable = 1'b0;
        byte_select  = 1'b0;
        addr         = '0;
        data_in      = '0;
        switches     = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check("led_out", 32'(led_out), 32'd0);
        check("snd_signals", 32'(snd_signals), 32'd0);
        check("snd_out", 32'(snd_out), 32'd0);
        check("data_out", 32'(data_out), 32'd0);
        check("serviced_read", 32'(serviced_read), 32'd0);
        check("tx", 32'(serial), 32'd1);
        check("mem_wait", 32'(mem_wait), 32'd0);

        fd = $fopen("sim/mmio_golden.txt", "r");
        if (fd == 0) begin
            stop_run("Could not open sim/mmio_golden.txt");
        end
        cmds = 0;
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#") begin
                f1 = '0;
                f2 = '0;
                f3 = '0;
                f4 = '0;
                n = $sscanf(line, "%c %h %h %h %h", op, f1, f2, f3, f4);
                cmds++;
                case (op)
                    "W": begin
                        bus_write(f1[15:0], f2[15:0], stalls);
                        check("mem_wait", 32'(stalls), 32'd0);
                        if (f1[15:0] == `LED_ADDR) begin
                            @(negedge clk);
                            check("led_out", 32'(led_out), 32'(f2[7:0]));
                        end
                    end
                    "R": begin
                        bus_read(f1[15:0], d);
                        check("data_out", 32'(d), f2);
                    end
                    "S": begin
                        @(posedge clk);
                        switches <= f1[3:0];
                        repeat (3) @(posedge clk);
                    end
                    "U": run_uart(f1[7:0], f2[7:0]);
                    "T": run_timer(f1[15:0], f2, f3[15:0], f4[15:0]);
                    "N": run_sound(f1[15:0], f2, f3[15:0]);
                    default: stop_run($sformatf("Unknown command in golden file: %s", line));
                endcase
                idle_gap();
            end
        end
        $fclose(fd);

        if (cmds == 0) begin
            stop_run("No commands found in the golden file");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

// File: all.f
+incdir+verilog
verilog/mmio_pkg.sv
verilog/uart_controller.sv
verilog/timer.sv
verilog/sound.sv
verilog/mmio.sv
sim/tb_mmio.sv

// File: Makefile
# Verilator build and run of the MMIO testbench

VERILATOR ?= verilator
TOP       ?= tb_mmio
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
FAIL_MSG  ?= test failed
PASS_MSG  ?= test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/mmio_golden.txt
# op W addr data | R addr expected | S switches | U byte1 byte2
# T load cycles low high | N word window toggles  (all fields hex)
W FF00 00A5
R FF00 00A5
W FF00 003C
R FF00 003C
S 9
R FF01 0009
S 6
R FF01 0006
# Unmapped and write-only addresses
R 1234 0000
R 00FE 0000
R FF10 0000
R FF05 0000
R FF06 0000
W FF06 3005
R FF06 0000
U 5A C3
U 01 80
U FF 00
T 1000 40 100F 1011
T FFFE 20 0005 0007
T 0000 0 FFFF 0001
# Sound level in bits 15:12, half period in 11:0
N 5003 78 14
N A00A C8 A
N F001 40 20
N 7000 40 0
N 2004 A0 14
R FF00 003C
